// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= sid_core_tb
FILELIST ?= sid_core.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= RESULT: PASS
SOURCES := $(shell cat $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/sid_core.sv ====
module sid_core (
	input  logic clk,
	input  logic reset,
	input  logic ce_1m,
	input  logic we,
	input  logic [sid_pkg::addr_width-1:0] addr,
	input  logic [sid_pkg::data_width-1:0] data_in,
	output logic [sid_pkg::data_width-1:0] data_out,
	input  logic [sid_pkg::data_width-1:0] pot_x,
	input  logic [sid_pkg::data_width-1:0] pot_y,
	output logic signed [sid_pkg::audio_width-1:0] audio_data
);

	logic [sid_pkg::freq_width-1:0] freq [sid_pkg::num_voices];
	logic [sid_pkg::pw_width-1:0] pw [sid_pkg::num_voices];
	logic [sid_pkg::data_width-1:0] control [sid_pkg::num_voices];
	logic [sid_pkg::data_width-1:0] att_dec [sid_pkg::num_voices];
	logic [sid_pkg::data_width-1:0] sus_rel [sid_pkg::num_voices];
	logic [sid_pkg::vol_width-1:0] volume;
	logic signed [sid_pkg::voice_width-1:0] voice_sig [sid_pkg::num_voices];
	logic [sid_pkg::data_width-1:0] osc3;
	logic [sid_pkg::env_width-1:0] env3;

	sid_regs i_regs (
		.clk(clk), .reset(reset), .we(we), .addr(addr), .data_in(data_in),
		.data_out(data_out), .pot_x(pot_x), .pot_y(pot_y), .osc3(osc3), .env3(env3),
		.freq(freq), .pw(pw), .control(control), .att_dec(att_dec), .sus_rel(sus_rel),
		.volume(volume)
	);

	// only voice 3 is visible on the read side.
	sid_voice i_voice1 (
		.clk(clk), .reset(reset), .ce_1m(ce_1m), .freq(freq[0]), .pw(pw[0]),
		.control(control[0]), .att_dec(att_dec[0]), .sus_rel(sus_rel[0]),
		.signal_out(voice_sig[0]), .osc_out(), .env_out()
	);

	sid_voice i_voice2 (
		.clk(clk), .reset(reset), .ce_1m(ce_1m), .freq(freq[1]), .pw(pw[1]),
		.control(control[1]), .att_dec(att_dec[1]), .sus_rel(sus_rel[1]),
		.signal_out(voice_sig[1]), .osc_out(), .env_out()
	);

	sid_voice i_voice3 (
		.clk(clk), .reset(reset), .ce_1m(ce_1m), .freq(freq[2]), .pw(pw[2]),
		.control(control[2]), .att_dec(att_dec[2]), .sus_rel(sus_rel[2]),
		.signal_out(voice_sig[2]), .osc_out(osc3), .env_out(env3)
	);

	sid_mixer i_mixer (
		.clk(clk), .reset(reset), .voice1(voice_sig[0]), .voice2(voice_sig[1]),
		.voice3(voice_sig[2]), .volume(volume), .audio_data(audio_data)
	);

endmodule

// ==== rtl/sid_envelope.sv ====
module sid_envelope (
	input  logic clk,
	input  logic reset,
	input  logic ce_1m,
	input  logic gate,
	input  logic [sid_pkg::data_width-1:0] att_dec,
	input  logic [sid_pkg::data_width-1:0] sus_rel,
	output logic [sid_pkg::env_width-1:0] env_out
);

	typedef enum logic [1:0] {
		st_attack,
		st_decay_sustain,
		st_release
	} env_state_t;

	env_state_t state;
	logic gate_d;
	logic [sid_pkg::presc_width-1:0] presc;
	logic [sid_pkg::presc_width-1:0] period;
	logic [sid_pkg::env_width-1:0] sustain;

	assign sustain = sus_rel[7:4] * sid_pkg::sustain_scale;

	always_comb begin
		case (state)
			st_attack:        period = sid_pkg::rate_period[att_dec[7:4]];
			st_decay_sustain: period = sid_pkg::rate_period[att_dec[3:0]] * sid_pkg::decay_factor;
			default:          period = sid_pkg::rate_period[sus_rel[3:0]] * sid_pkg::decay_factor;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= st_release;
			gate_d  <= 1'b0;
			presc   <= '0;
			env_out <= '0;
		end else begin
			gate_d <= gate;
			if (gate && !gate_d) begin
				state <= st_attack; // a new note restarts the count.
				presc <= '0;
			end else if (!gate && gate_d) begin
				state <= st_release;
				presc <= '0;
			end else if (ce_1m) begin
				if (presc == period - 1'b1) begin
					presc <= '0;
					case (state)
						st_attack: begin
							if (env_out != 8'hff)
								env_out <= env_out + 1'b1;
							if (env_out >= 8'hfe)
								state <= st_decay_sustain; // peak reached on this step.
						end
						st_decay_sustain: begin
							if (env_out > sustain)
								env_out <= env_out - 1'b1;
						end
						default: begin
							if (env_out != '0)
								env_out <= env_out - 1'b1;
						end
					endcase
				end else begin
					presc <= presc + 1'b1;
				end
			end
		end
	end

	a_env_no_underflow: assert property (@(posedge clk) disable iff (reset)
		env_out == '0 |=> env_out <= 8'd1);

endmodule

// ==== rtl/sid_mixer.sv ====
module sid_mixer (
	input  logic clk,
	input  logic reset,
	input  logic signed [sid_pkg::voice_width-1:0] voice1,
	input  logic signed [sid_pkg::voice_width-1:0] voice2,
	input  logic signed [sid_pkg::voice_width-1:0] voice3,
	input  logic [sid_pkg::vol_width-1:0] volume,
	output logic signed [sid_pkg::audio_width-1:0] audio_data
);

	logic signed [sid_pkg::voice_width+1:0] sum;
	logic signed [sid_pkg::audio_width+1:0] scaled;

	always_comb begin
		sum = voice1 + voice2 + voice3; // two guard bits cover three voices.
		scaled = sum * $signed({1'b0, volume});
	end

	always_ff @(posedge clk) begin
		if (reset)
			audio_data <= '0;
		else
			audio_data <= scaled[sid_pkg::audio_width-1:0];
	end

	// the registered output must carry the full product without clipping.
	a_audio_fits: assert property (@(posedge clk) disable iff (reset)
		scaled[sid_pkg::audio_width+1:sid_pkg::audio_width-1] inside {3'b000, 3'b111});

endmodule

// ==== rtl/sid_pkg.sv ====
package sid_pkg;

	localparam int addr_width  = 5;
	localparam int data_width  = 8;
	localparam int num_voices  = 3;
	localparam int freq_width  = 16;
	localparam int pw_width    = 12;
	localparam int vol_width   = 4;
	localparam int acc_width   = 24;
	localparam int wave_width  = 12;
	localparam int env_width   = 8;
	localparam int voice_width = 12;
	localparam int audio_width = 18;
	localparam int presc_width = 18; // holds the longest decay period, 3 x 65536.

	localparam int addr_freq_lo = 0;
	localparam int addr_freq_hi = 1;
	localparam int addr_pw_lo   = 2;
	localparam int addr_pw_hi   = 3;
	localparam int addr_control = 4;
	localparam int addr_att_dec = 5;
	localparam int addr_sus_rel = 6;
	localparam int voice_stride = 7;

	localparam logic [addr_width-1:0] addr_mode_vol = 5'h18;
	localparam logic [addr_width-1:0] addr_pot_x    = 5'h19;
	localparam logic [addr_width-1:0] addr_pot_y    = 5'h1a;
	localparam logic [addr_width-1:0] addr_osc3     = 5'h1b;
	localparam logic [addr_width-1:0] addr_env3     = 5'h1c;

	localparam int ctrl_gate     = 0;
	localparam int ctrl_test     = 3;
	localparam int ctrl_triangle = 4;
	localparam int ctrl_sawtooth = 5;
	localparam int ctrl_pulse    = 6;

	localparam logic [presc_width-1:0] rate_period [16] = '{
		18'd2, 18'd4, 18'd8, 18'd16, 18'd32, 18'd64, 18'd128, 18'd256,
		18'd512, 18'd1024, 18'd2048, 18'd4096, 18'd8192, 18'd16384, 18'd32768, 18'd65536
	};
	localparam logic [presc_width-1:0] decay_factor = 18'd3;
	localparam logic [env_width-1:0] sustain_scale = 8'd17;

endpackage

// ==== rtl/sid_regs.sv ====
module sid_regs (
	input  logic clk,
	input  logic reset,
	input  logic we,
	input  logic [sid_pkg::addr_width-1:0] addr,
	input  logic [sid_pkg::data_width-1:0] data_in,
	output logic [sid_pkg::data_width-1:0] data_out,
	input  logic [sid_pkg::data_width-1:0] pot_x,
	input  logic [sid_pkg::data_width-1:0] pot_y,
	input  logic [sid_pkg::data_width-1:0] osc3,
	input  logic [sid_pkg::data_width-1:0] env3,
	output logic [sid_pkg::freq_width-1:0] freq [sid_pkg::num_voices],
	output logic [sid_pkg::pw_width-1:0] pw [sid_pkg::num_voices],
	output logic [sid_pkg::data_width-1:0] control [sid_pkg::num_voices],
	output logic [sid_pkg::data_width-1:0] att_dec [sid_pkg::num_voices],
	output logic [sid_pkg::data_width-1:0] sus_rel [sid_pkg::num_voices],
	output logic [sid_pkg::vol_width-1:0] volume
);

	logic [sid_pkg::data_width-1:0] last_wr;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int v = 0; v < sid_pkg::num_voices; v++) begin
				freq[v]    <= '0;
				pw[v]      <= '0;
				control[v] <= '0;
				att_dec[v] <= '0;
				sus_rel[v] <= '0;
			end
			volume  <= '0;
			last_wr <= '0;
		end else if (we) begin
			last_wr <= data_in; // filter addresses only land here.
			for (int v = 0; v < sid_pkg::num_voices; v++) begin
				if (int'(addr) == v * sid_pkg::voice_stride + sid_pkg::addr_freq_lo)
					freq[v][7:0] <= data_in;
				if (int'(addr) == v * sid_pkg::voice_stride + sid_pkg::addr_freq_hi)
					freq[v][15:8] <= data_in;
				if (int'(addr) == v * sid_pkg::voice_stride + sid_pkg::addr_pw_lo)
					pw[v][7:0] <= data_in;
				if (int'(addr) == v * sid_pkg::voice_stride + sid_pkg::addr_pw_hi)
					pw[v][11:8] <= data_in[3:0]; // only a nibble exists on the chip.
				if (int'(addr) == v * sid_pkg::voice_stride + sid_pkg::addr_control)
					control[v] <= data_in;
				if (int'(addr) == v * sid_pkg::voice_stride + sid_pkg::addr_att_dec)
					att_dec[v] <= data_in;
				if (int'(addr) == v * sid_pkg::voice_stride + sid_pkg::addr_sus_rel)
					sus_rel[v] <= data_in;
			end
			if (addr == sid_pkg::addr_mode_vol)
				volume <= data_in[3:0];
		end
	end

	// write-only registers read back as the last byte on the bus.
	always_comb begin
		case (addr)
			sid_pkg::addr_pot_x: data_out = pot_x;
			sid_pkg::addr_pot_y: data_out = pot_y;
			sid_pkg::addr_osc3:  data_out = osc3;
			sid_pkg::addr_env3:  data_out = env3;
			default:             data_out = last_wr;
		endcase
	end

	a_we_addr_known: assert property (@(posedge clk) disable iff (reset)
		we |-> !$isunknown(addr));

endmodule

// ==== rtl/sid_voice.sv ====
module sid_voice (
	input  logic clk,
	input  logic reset,
	input  logic ce_1m,
	input  logic [sid_pkg::freq_width-1:0] freq,
	input  logic [sid_pkg::pw_width-1:0] pw,
	input  logic [sid_pkg::data_width-1:0] control,
	input  logic [sid_pkg::data_width-1:0] att_dec,
	input  logic [sid_pkg::data_width-1:0] sus_rel,
	output logic signed [sid_pkg::voice_width-1:0] signal_out,
	output logic [sid_pkg::data_width-1:0] osc_out,
	output logic [sid_pkg::env_width-1:0] env_out
);

	logic [sid_pkg::acc_width-1:0] acc;
	logic ce_d;
	logic [sid_pkg::wave_width-1:0] sawtooth;
	logic [sid_pkg::wave_width-1:0] triangle;
	logic [sid_pkg::wave_width-1:0] pulse;
	logic [sid_pkg::wave_width-1:0] wave;
	logic [sid_pkg::wave_width-1:0] wave_q;
	logic signed [sid_pkg::wave_width-1:0] centered;
	logic signed [sid_pkg::wave_width+sid_pkg::env_width:0] scaled;

	sid_envelope i_envelope (
		.clk(clk),
		.reset(reset),
		.ce_1m(ce_1m),
		.gate(control[sid_pkg::ctrl_gate]),
		.att_dec(att_dec),
		.sus_rel(sus_rel),
		.env_out(env_out)
	);

	always_comb begin
		sawtooth = acc[sid_pkg::acc_width-1 -: sid_pkg::wave_width];
		triangle = {sawtooth[sid_pkg::wave_width-2:0]
			^ {(sid_pkg::wave_width-1){sawtooth[sid_pkg::wave_width-1]}}, 1'b0};
		pulse = (sawtooth < pw) ? '1 : '0;
		wave = '1;
		if (control[sid_pkg::ctrl_sawtooth])
			wave = wave & sawtooth;
		if (control[sid_pkg::ctrl_triangle])
			wave = wave & triangle;
		if (control[sid_pkg::ctrl_pulse])
			wave = wave & pulse;
		if (!(control[sid_pkg::ctrl_sawtooth] || control[sid_pkg::ctrl_triangle]
			|| control[sid_pkg::ctrl_pulse]))
			wave = '0; // a silent voice sits at the bottom rail.
		centered = {~wave[sid_pkg::wave_width-1], wave[sid_pkg::wave_width-2:0]};
		scaled = centered * $signed({1'b0, env_out});
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			acc        <= '0;
			ce_d       <= 1'b0;
			wave_q     <= '0;
			signal_out <= '0;
		end else begin
			ce_d <= ce_1m;
			if (control[sid_pkg::ctrl_test])
				acc <= '0;
			else if (ce_1m)
				acc <= acc + {{(sid_pkg::acc_width-sid_pkg::freq_width){1'b0}}, freq};
			if (ce_d) begin
				wave_q     <= wave; // sampled one cycle after the phase step.
				signal_out <= scaled[sid_pkg::voice_width+sid_pkg::env_width-1:sid_pkg::env_width];
			end
		end
	end

	assign osc_out = wave_q[sid_pkg::wave_width-1 -: sid_pkg::data_width];

	a_ce_spacing: assert property (@(posedge clk) disable iff (reset)
		ce_1m |=> !ce_1m [*3]);

endmodule

// ==== sid_core.f ====
rtl/sid_pkg.sv
rtl/sid_regs.sv
rtl/sid_envelope.sv
rtl/sid_voice.sv
rtl/sid_mixer.sv
rtl/sid_core.sv
verification/sid_core_tb.sv

// ==== verification/sid_core_tb.sv ====
module sid_core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int max_cycles = 20000;
	localparam logic [7:0] gate_bit = 8'h01;
	localparam logic [7:0] test_bit = 8'h08;
	localparam logic [7:0] tri_bit = 8'h10;
	localparam logic [7:0] saw_bit = 8'h20;
	localparam logic [7:0] pulse_bit = 8'h40;
	localparam int attack_nibble = 0;
	localparam int decay_nibble = 1; // decay runs slower than attack and release.
	localparam int release_nibble = 0;
	localparam int sustain_nibble = 14;
	localparam int sustain_level = sustain_nibble * sid_pkg::sustain_scale;

	logic clk = 1'b0;
	logic reset;
	logic ce_1m;
	logic we;
	logic [4:0] addr;
	logic [7:0] data_in;
	logic [7:0] data_out;
	logic [7:0] pot_x;
	logic [7:0] pot_y;
	logic signed [17:0] audio_data;
	logic [31:0] lcg_state = 32'd31;
	int cycles = 0;
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;

	sid_core i_sid_core (
		.clk(clk), .reset(reset), .ce_1m(ce_1m), .we(we), .addr(addr), .data_in(data_in),
		.data_out(data_out), .pot_x(pot_x), .pot_y(pot_y), .audio_data(audio_data)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles == max_cycles) begin
			$display("the tests did not finish within %0d cycles", max_cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	// the triangle mirrors the upper half of the phase back down.
	function automatic logic [7:0] osc_from_phase(input logic [23:0] phase, input logic fold);
		logic [11:0] top;
		top = phase[23:12];
		if (fold)
			top = (top[11] ? ~top : top) << 1;
		return top[11:4];
	endfunction

	// rate table entry i is 2 << i strobes per step.
	function automatic int rate_strobes(input int nibble);
		return 2 << nibble;
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic write_reg(input logic [4:0] a, input logic [7:0] d);
		we = 1'b1;
		addr = a;
		data_in = d;
		tick();
		we = 1'b0;
		tick(); // the envelope sees a gate change one edge after the write.
	endtask

	task automatic read_reg(input logic [4:0] a, output logic [7:0] d);
		addr = a;
		#1 d = data_out;
		tick();
	endtask

	task automatic strobe(input int n);
		repeat (n) begin
			ce_1m = 1'b1;
			tick();
			ce_1m = 1'b0;
			repeat (7) tick();
		end
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		$display("Error %s expected %h got %h", name, exp, got);
		errors++;
		test_errors++;
	endtask

	task automatic finish_test(input string name);
		$display("test %s done with %0d errors", name, test_errors);
		tests_run++;
		test_errors = 0;
	endtask

	task automatic test_reset();
		logic [4:0] addrs [5] = '{5'h00, 5'h0e, 5'h18, sid_pkg::addr_osc3, sid_pkg::addr_env3};
		logic [7:0] d;
		if (audio_data !== 18'h0)
			report_mismatch("audio_data", 0, audio_data);
		foreach (addrs[i]) begin
			read_reg(addrs[i], d);
			if (d !== 8'h00)
				report_mismatch("data_out", 0, d);
		end
		finish_test("reset");
	endtask

	task automatic test_readback();
		logic [4:0] wr_addrs [6] = '{5'h07, 5'h08, 5'h15, 5'h16, 5'h17, 5'h18};
		logic [4:0] rd_addrs [5] = '{5'h00, 5'h0b, 5'h18, 5'h1d, 5'h1f};
		logic [7:0] value;
		logic [7:0] d;
		foreach (wr_addrs[w]) begin
			value = lcg_byte();
			write_reg(wr_addrs[w], value);
			foreach (rd_addrs[r]) begin
				read_reg(rd_addrs[r], d);
				if (d !== value)
					report_mismatch("data_out", value, d);
			end
		end
		repeat (4) begin
			pot_x = lcg_byte();
			pot_y = lcg_byte();
			read_reg(sid_pkg::addr_pot_x, d);
			if (d !== pot_x)
				report_mismatch("pot_x", pot_x, d);
			read_reg(sid_pkg::addr_pot_y, d);
			if (d !== pot_y)
				report_mismatch("pot_y", pot_y, d);
		end
		finish_test("readback");
	endtask

	task automatic sweep_osc(input logic [15:0] f, input logic [7:0] wave, input logic fold,
		input int n);
		logic [23:0] phase;
		logic [7:0] d;
		write_reg(5'h0e, f[7:0]);
		write_reg(5'h0f, f[15:8]);
		write_reg(5'h12, wave | test_bit); // voice 3 restarts at phase zero.
		write_reg(5'h12, wave);
		phase = '0;
		repeat (n) begin
			strobe(1);
			phase = phase + {8'h00, f};
			read_reg(sid_pkg::addr_osc3, d);
			if (d !== osc_from_phase(phase, fold))
				report_mismatch("osc3", osc_from_phase(phase, fold), d);
		end
	endtask

	task automatic test_oscillator();
		sweep_osc(16'hf0a3, saw_bit, 1'b0, 16);
		sweep_osc(16'hffff, tri_bit, 1'b1, 132); // long enough to pass the phase midpoint.
		finish_test("oscillator");
	endtask

	task automatic check_env_after(input int strobes, input int level);
		logic [7:0] d;
		strobe(strobes);
		read_reg(sid_pkg::addr_env3, d);
		if (d !== 8'(level))
			report_mismatch("env3", level, d);
	endtask

	task automatic test_envelope();
		int level;
		write_reg(5'h03, 8'h08); // voice 1 becomes the full-scale pulse for the audio test.
		write_reg(5'h06, 8'hf0);
		write_reg(5'h04, pulse_bit | test_bit | gate_bit);
		write_reg(5'h13, 8'(attack_nibble * 16 + decay_nibble));
		write_reg(5'h14, 8'(sustain_nibble * 16 + release_nibble));
		write_reg(5'h12, gate_bit);
		for (level = 1; level <= 255; level++)
			check_env_after(rate_strobes(attack_nibble), level);
		for (level = 254; level >= sustain_level; level--)
			check_env_after(3 * rate_strobes(decay_nibble), level);
		check_env_after(3 * rate_strobes(decay_nibble), sustain_level);
		write_reg(5'h12, 8'h00);
		for (level = sustain_level - 1; level >= 0; level--)
			check_env_after(3 * rate_strobes(release_nibble), level);
		finish_test("envelope");
	endtask

	task automatic test_audio();
		int volumes [3] = '{15, 7, 0};
		int exp;
		foreach (volumes[i]) begin
			write_reg(sid_pkg::addr_mode_vol, 8'(volumes[i]));
			strobe(1);
			exp = ((2047 * 255) >>> 8) * volumes[i];
			if (audio_data !== 18'(exp))
				report_mismatch("audio_data", exp, audio_data);
		end
		finish_test("audio");
	endtask

	initial begin
		reset = 1'b1;
		ce_1m = 1'b0;
		we = 1'b0;
		addr = '0;
		data_in = '0;
		pot_x = '0;
		pot_y = '0;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		tick();
		test_reset();
		test_readback();
		test_oscillator();
		test_envelope();
		test_audio();
		$display("%0d tests run, %0d checks failed", tests_run, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
